//--- verilog/fabric_pkg.sv
package fabric_pkg;

  // upper 16 address bits, one 64 KiB region each
  typedef enum logic [15:0] {
    REG_SRAM  = 16'h0200,  // main sram
    REG_CACHE = 16'h0201,  // cache flush control
    REG_IRQ   = 16'h0202,  // interrupt pending bits
    REG_VGA   = 16'h0206,  // vga regs + cursor image
    REG_HID   = 16'h0207   // hid serial receiver
  } region_t;

  localparam int IRQ_SRCS = 3;  // timer, uart, hid

  typedef struct packed {
    logic [31:0] address;     // byte address
    logic        read;        // held until waitrequest low
    logic        write;       // same
    logic [31:0] writedata;
    logic [3:0]  byteenable;  // one bit per byte lane
  } bus_req_t;

  typedef struct packed {
    logic [31:0] readdata;     // valid in completing cycle
    logic        waitrequest;  // stall while high
  } bus_rsp_t;

  typedef struct packed {
    logic sram;
    logic cache;
    logic irq;
    logic vga;
    logic hid;
  } sel_t;

  // low address half, seen as register select or as word index
  typedef union packed {
    struct packed {
      logic [2:0]  rsel;  // vga register select
      logic [12:0] rest;
    } reg_view;
    struct packed {
      logic [13:0] index;  // word index
      logic [1:0]  lane;   // byte lane
    } word_view;
  } offset_u;

  typedef struct packed {
    logic        mode;       // display mode
    logic        block;      // blank the screen
    logic [15:0] line_base;  // first line address
    logic [9:0]  cursor_x;
    logic [9:0]  cursor_y;
  } vga_ctrl_t;

endpackage

//--- verilog/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric import fabric_pkg::*; (
  input  bus_req_t req,
  input  bus_rsp_t sram_rsp,
  input  bus_rsp_t irq_rsp,
  input  bus_rsp_t hid_rsp,
  output sel_t     sel,
  output bus_rsp_t rsp
);

  logic [15:0] region;  // region code of current request

  assign region = req.address[31:16];

  // decode, one select per mapped region
  always_comb begin
    sel.sram  = (region == REG_SRAM);
    sel.cache = (region == REG_CACHE);
    sel.irq   = (region == REG_IRQ);
    sel.vga   = (region == REG_VGA);
    sel.hid   = (region == REG_HID);
  end

  // cache and vga have no read path, so they never show up here
  // unmapped regions fall through to zero data, no wait
  always_comb begin
    rsp.readdata    = ({32{sel.sram}} & sram_rsp.readdata) |
                      ({32{sel.irq}}  & irq_rsp.readdata)  |
                      ({32{sel.hid}}  & hid_rsp.readdata);
    rsp.waitrequest = (sel.sram & sram_rsp.waitrequest) |
                      (sel.irq  & irq_rsp.waitrequest)  |
                      (sel.hid  & hid_rsp.waitrequest);
  end

endmodule

//--- verilog/sram_port.sv
`timescale 1ns/1ps

module sram_port import fabric_pkg::*; #(
  parameter int SRAM_WORDS = 512  // power of two, up to 16384
) (
  input  logic     clk,
  input  logic     reset_n,
  input  bus_req_t req,
  input  logic     sel,
  output bus_rsp_t rsp
);

  localparam int AW = $clog2(SRAM_WORDS);

  logic [31:0]   mem [SRAM_WORDS];  // main sram array
  logic [AW-1:0] idx;               // word index
  logic [31:0]   rd_data;           // registered read word
  logic          rd_req;            // read aimed at us
  logic          ack;               // read data ready

  assign idx    = req.address[AW+1:2];
  assign rd_req = sel & req.read;

  always_ff @(posedge clk) begin
    if (sel && req.write) begin
      for (int i = 0; i < 4; i++) begin
        if (req.byteenable[i]) begin
          mem[idx][8*i +: 8] <= req.writedata[8*i +: 8];  // enabled lanes only
        end
      end
    end
    rd_data <= mem[idx];  // sampled during the wait cycle
  end

  // one-cycle ack, so every read sees exactly one wait state
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack <= 1'b0;
    end else begin
      ack <= rd_req & ~ack;  // drops on completion or when read drops
    end
  end

  assign rsp.readdata    = rd_data;
  assign rsp.waitrequest = rd_req & ~ack;

endmodule

//--- verilog/sys_ctrl.sv
`timescale 1ns/1ps

module sys_ctrl import fabric_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  bus_req_t    req,
  input  logic        cache_sel,
  input  logic        irq_sel,
  input  logic        timer_irq,
  input  logic        uart_irq,
  input  logic        hid_event,
  output bus_rsp_t    rsp,
  output logic        irq_req,
  output logic        flush_cache,
  output logic [14:0] flush_page
);

  logic [1:0]          ext_meta;  // timer, uart first stage
  logic [1:0]          ext_sync;  // synchronized level
  logic [1:0]          ext_prev;  // last synchronized sample
  logic [IRQ_SRCS-1:0] irq_set;   // rising edges this cycle
  logic [IRQ_SRCS-1:0] irq_clr;   // write-one-to-clear mask
  logic [IRQ_SRCS-1:0] pending;
  logic                word0;     // offset hits word 0

  assign word0   = (req.address[15:2] == 14'd0);
  assign irq_set = {hid_event, ext_sync & ~ext_prev};  // hid already a pulse
  assign irq_clr = (irq_sel && req.write && word0) ? req.writedata[IRQ_SRCS-1:0] : '0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ext_meta    <= '0;
      ext_sync    <= '0;
      ext_prev    <= '0;
      pending     <= '0;
      flush_cache <= 1'b0;
      flush_page  <= '0;
    end else begin
      ext_meta <= {uart_irq, timer_irq};
      ext_sync <= ext_meta;
      ext_prev <= ext_sync;
      pending  <= (pending & ~irq_clr) | irq_set;  // set beats clear
      if (cache_sel && req.write && word0) begin  // other words ignored
        flush_cache <= req.writedata[31];
        flush_page  <= req.writedata[14:0];
      end
    end
  end

  assign irq_req         = |pending;
  assign rsp.readdata    = 32'(pending);  // zero-extended
  assign rsp.waitrequest = 1'b0;

endmodule

//--- verilog/vga_regs.sv
`timescale 1ns/1ps

module vga_regs import fabric_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  bus_req_t    req,
  input  logic        sel,
  input  logic [9:0]  cursor_rd_addr,
  output vga_ctrl_t   ctrl,
  output logic [15:0] cursor_rd_data
);

  offset_u     off;                   // region offset, two views
  logic        wr_en;                 // write into vga region
  logic [15:0] cursor_mem [1024];     // 32x32 cursor image

  assign off   = req.address[15:0];
  assign wr_en = sel & req.write;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl.mode      <= 1'b1;  // default display mode
      ctrl.block     <= 1'b0;
      ctrl.line_base <= '0;
      ctrl.cursor_x  <= '0;
      ctrl.cursor_y  <= '0;
    end else if (wr_en) begin
      case (off.reg_view.rsel)
        3'd0: ctrl.mode      <= req.writedata[0];
        3'd1: ctrl.block     <= req.writedata[0];
        3'd2: ctrl.line_base <= req.writedata[15:0];
        3'd4: ctrl.cursor_x  <= req.writedata[9:0];
        3'd5: ctrl.cursor_y  <= req.writedata[9:0];
        default: ;  // 3 is the cursor ram, 6 and 7 unused
      endcase
    end
  end

  // cursor ram write, select 3 picks it, word index gives the pixel
  always_ff @(posedge clk) begin
    if (wr_en && off.reg_view.rsel == 3'd3) begin
      cursor_mem[off.word_view.index[9:0]] <= req.writedata[15:0];
    end
  end

  // display side read port, one cycle latency
  always_ff @(posedge clk) begin
    cursor_rd_data <= cursor_mem[cursor_rd_addr];
  end

endmodule

//--- verilog/hid_rx.sv
`timescale 1ns/1ps

module hid_rx import fabric_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  bus_req_t req,
  input  logic     sel,
  input  logic     hid_dat,
  input  logic     hid_clk,
  input  logic     hid_str,
  output bus_rsp_t rsp,
  output logic     hid_event
);

  logic [2:0]  in_meta;   // {str, clk, dat} first stage
  logic [2:0]  in_sync;   // second stage
  logic [1:0]  in_prev;   // {str, clk} previous sample
  logic        clk_rise;
  logic        str_rise;
  logic        parity_ok;
  logic        arrived;   // word waiting to be read
  logic [31:0] shift_q;   // lsb arrives first, shifted down

  assign clk_rise  = in_sync[1] & ~in_prev[0];
  assign str_rise  = in_sync[2] & ~in_prev[1];
  assign parity_ok = (^shift_q[24:0]) == shift_q[28];  // parity bit at 28

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      in_meta   <= '0;
      in_sync   <= '0;
      in_prev   <= '0;
      shift_q   <= '0;
      arrived   <= 1'b0;
      hid_event <= 1'b0;
    end else begin
      in_meta   <= {hid_str, hid_clk, hid_dat};  // dat kept aligned with clk
      in_sync   <= in_meta;
      in_prev   <= in_sync[2:1];
      hid_event <= str_rise;  // one pulse per strobe
      if (clk_rise) shift_q <= {in_sync[0], shift_q[31:1]};
      if (sel && req.read) arrived <= 1'b0;  // read consumes the word
      if (str_rise && parity_ok) arrived <= 1'b1;  // set beats clear
    end
  end

  assign rsp.readdata    = arrived ? shift_q : 32'd0;
  assign rsp.waitrequest = 1'b0;

endmodule

//--- verilog/cpu_bus_system.sv
`timescale 1ns/1ps

module cpu_bus_system import fabric_pkg::*; #(
  parameter int SRAM_WORDS = 512  // main sram depth in words
) (
  input  logic        clk,
  input  logic        reset_n,
  input  bus_req_t    bus_req,
  input  logic        timer_irq,
  input  logic        uart_irq,
  input  logic        hid_dat,
  input  logic        hid_clk,
  input  logic        hid_str,
  input  logic [9:0]  cursor_rd_addr,
  output bus_rsp_t    bus_rsp,
  output logic        irq_req,
  output logic        flush_cache,
  output logic [14:0] flush_page,
  output vga_ctrl_t   vga_ctrl,
  output logic [15:0] cursor_rd_data
);

  sel_t     sel;        // per-region selects
  bus_rsp_t sram_rsp;
  bus_rsp_t irq_rsp;
  bus_rsp_t hid_rsp;
  logic     hid_event;  // strobe pulse into irq ctrl

  bus_fabric bus_fabric_i (
    .req      (bus_req),
    .sram_rsp (sram_rsp),
    .irq_rsp  (irq_rsp),
    .hid_rsp  (hid_rsp),
    .sel      (sel),
    .rsp      (bus_rsp)
  );

  sram_port #(.SRAM_WORDS(SRAM_WORDS)) sram_port_i (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (bus_req),
    .sel     (sel.sram),
    .rsp     (sram_rsp)
  );

  sys_ctrl sys_ctrl_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .req         (bus_req),
    .cache_sel   (sel.cache),
    .irq_sel     (sel.irq),
    .timer_irq   (timer_irq),
    .uart_irq    (uart_irq),
    .hid_event   (hid_event),
    .rsp         (irq_rsp),
    .irq_req     (irq_req),
    .flush_cache (flush_cache),
    .flush_page  (flush_page)
  );

  vga_regs vga_regs_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .req            (bus_req),
    .sel            (sel.vga),
    .cursor_rd_addr (cursor_rd_addr),
    .ctrl           (vga_ctrl),
    .cursor_rd_data (cursor_rd_data)
  );

  hid_rx hid_rx_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .req       (bus_req),
    .sel       (sel.hid),
    .hid_dat   (hid_dat),
    .hid_clk   (hid_clk),
    .hid_str   (hid_str),
    .rsp       (hid_rsp),
    .hid_event (hid_event)
  );

endmodule

//--- tb/tb_cpu_bus_system.sv
`timescale 1ns/1ps

module tb_cpu_bus_system import fabric_pkg::*; ();

  localparam int N_SLOTS = 16;  // sram words in play
  localparam int N_SRAM  = 60;
  localparam int N_REG   = 30;
  localparam int N_CUR   = 20;
  localparam int N_IRQ   = 12;
  localparam int N_HID   = 4;   // received words
  // ops weighted by rough cost where one hid bit counts as one op
  localparam int OPS = N_SLOTS + N_SRAM + N_REG + 2 * N_CUR + 3 * N_IRQ + N_HID * 40 + 8;

  logic        clk;
  logic        reset_n;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic        timer_irq, uart_irq, hid_dat, hid_clk, hid_str;
  logic [9:0]  cursor_rd_addr;
  logic        irq_req, flush_cache;
  logic [14:0] flush_page;
  vga_ctrl_t   vga_ctrl;
  logic [15:0] cursor_rd_data;

  logic [31:0]         lfsr = 32'hf37f4c09;
  logic [31:0]         sram_m [512];   // reference sram
  logic [15:0]         cur_m [1024];   // reference cursor image
  vga_ctrl_t           vga_m;
  logic                fc_m;
  logic [14:0]         fp_m;
  logic [IRQ_SRCS-1:0] pend_m;         // reference pending bits

  cpu_bus_system #(.SRAM_WORDS(512)) cpu_bus_system_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .bus_req        (bus_req),
    .timer_irq      (timer_irq),
    .uart_irq       (uart_irq),
    .hid_dat        (hid_dat),
    .hid_clk        (hid_clk),
    .hid_str        (hid_str),
    .cursor_rd_addr (cursor_rd_addr),
    .bus_rsp        (bus_rsp),
    .irq_req        (irq_req),
    .flush_cache    (flush_cache),
    .flush_page     (flush_page),
    .vga_ctrl       (vga_ctrl),
    .cursor_rd_data (cursor_rd_data)
  );

  always #4 clk = ~clk;  // 8 ns period

  // galois lfsr with taps 32 22 2 1
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h80200003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], rand_bit()};
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // level handshake holds the request until waitrequest low
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be, output logic [31:0] rdata, output int waits);
    @(posedge clk);
    bus_req.address    <= addr;
    bus_req.writedata  <= data;
    bus_req.byteenable <= be;
    bus_req.write      <= wr;
    bus_req.read       <= ~wr;
    waits = 0;
    @(negedge clk);
    while (bus_rsp.waitrequest) begin
      waits++;
      @(negedge clk);
    end
    rdata = bus_rsp.readdata;  // completing cycle
    @(posedge clk);
    bus_req.read  <= 1'b0;
    bus_req.write <= 1'b0;
  endtask

  // writes never wait
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
    logic [31:0] rd;
    int          w;
    bus_access(1'b1, addr, data, be, rd, w);
    check("write wait cycles", 32'(w), 32'd0);
  endtask

  // non-sram reads never wait
  task automatic read_expect(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    int          w;
    bus_access(1'b0, addr, 32'd0, 4'hf, rd, w);
    check(name, rd, exp);
    check({name, " wait cycles"}, 32'(w), 32'd0);
  endtask

  task automatic check_outputs();
    @(negedge clk);
    check("vga_ctrl.mode", 32'(vga_ctrl.mode), 32'(vga_m.mode));
    check("vga_ctrl.block", 32'(vga_ctrl.block), 32'(vga_m.block));
    check("vga_ctrl.line_base", 32'(vga_ctrl.line_base), 32'(vga_m.line_base));
    check("vga_ctrl.cursor_x", 32'(vga_ctrl.cursor_x), 32'(vga_m.cursor_x));
    check("vga_ctrl.cursor_y", 32'(vga_ctrl.cursor_y), 32'(vga_m.cursor_y));
    check("flush_cache", 32'(flush_cache), 32'(fc_m));
    check("flush_page", 32'(flush_page), 32'(fp_m));
  endtask

  task automatic sram_traffic();
    logic [8:0]  slot [N_SLOTS];
    logic [31:0] data, rd, addr;
    logic [3:0]  be, k;
    int          w;
    for (int i = 0; i < N_SLOTS; i++) begin  // full words first so reads never see x
      slot[i] = 9'(rand_bits(9));
      data = rand_bits(32);
      sram_m[slot[i]] = data;
      bus_write({REG_SRAM, 5'(rand_bits(5)), slot[i], 2'b00}, data, 4'hf);
    end
    for (int n = 0; n < N_SRAM; n++) begin
      k    = 4'(rand_bits(4));
      addr = {REG_SRAM, 5'(rand_bits(5)), slot[k], 2'b00};  // upper offset bits ignored
      if (rand_bit()) begin
        data = rand_bits(32);
        be   = 4'(rand_bits(4));
        for (int i = 0; i < 4; i++)
          if (be[i]) sram_m[slot[k]][8*i +: 8] = data[8*i +: 8];
        bus_write(addr, data, be);
      end else begin
        bus_access(1'b0, addr, 32'd0, 4'hf, rd, w);
        check("sram readdata", rd, sram_m[slot[k]]);
        check("sram wait cycles", 32'(w), 32'd1);
      end
    end
  endtask

  task automatic control_writes();
    logic [2:0]  c;
    logic [2:0]  rsel;
    logic [31:0] data;
    logic [13:0] word;
    check_outputs();  // reset values
    for (int n = 0; n < N_REG; n++) begin
      c    = 3'(rand_bits(3));
      data = rand_bits(32);
      if (c == 3'd5) begin
        fc_m = data[31];
        fp_m = data[14:0];
        bus_write({REG_CACHE, 16'h0000}, data, 4'hf);
      end else if (c == 3'd6) begin
        word = 14'(rand_bits(14)) | 14'd1;  // nonzero word is ignored
        bus_write({REG_CACHE, word, 2'b00}, data, 4'hf);
      end else begin
        case (c)
          3'd0: rsel = 3'd0;
          3'd1: rsel = 3'd1;
          3'd2: rsel = 3'd2;
          3'd3: rsel = 3'd4;
          3'd4: rsel = 3'd5;
          default: rsel = 3'd6 + 3'(rand_bit());  // unused selects
        endcase
        case (rsel)
          3'd0: vga_m.mode = data[0];
          3'd1: vga_m.block = data[0];
          3'd2: vga_m.line_base = data[15:0];
          3'd4: vga_m.cursor_x = data[9:0];
          3'd5: vga_m.cursor_y = data[9:0];
          default: ;
        endcase
        bus_write({REG_VGA, rsel, 13'(rand_bits(13))}, data, 4'hf);
      end
      check_outputs();
    end
  endtask

  task automatic cursor_image();
    logic [9:0]  q [$];
    logic [9:0]  a;
    logic [15:0] d;
    for (int n = 0; n < N_CUR; n++) begin
      a = 10'(rand_bits(10));
      d = 16'(rand_bits(16));
      cur_m[a] = d;
      q.push_back(a);
      bus_write({REG_VGA, 3'd3, rand_bit(), a, 2'b00}, {16'(rand_bits(16)), d}, 4'hf);
    end
    foreach (q[i]) begin
      @(posedge clk);
      cursor_rd_addr <= q[i];
      @(posedge clk);
      @(negedge clk);  // one cycle after the address
      check("cursor_rd_data", 32'(cursor_rd_data), 32'(cur_m[q[i]]));
    end
  endtask

  task automatic hold_pins(input logic c, input logic s, input logic d);
    @(posedge clk);
    hid_clk <= c;
    hid_str <= s;
    hid_dat <= d;
    repeat (3) @(posedge clk);  // each level for 4 cycles
  endtask

  task automatic check_pending();
    read_expect("irq pending", {REG_IRQ, 16'h0000}, 32'(pend_m));
    check("irq_req", 32'(irq_req), 32'(|pend_m));
  endtask

  task automatic irq_edges();
    logic [1:0] src;
    logic [2:0] mask;
    for (int n = 0; n < N_IRQ; n++) begin
      src = 2'(rand_bits(2));
      @(posedge clk);
      timer_irq <= src[0];
      uart_irq  <= src[1];
      repeat (4) @(posedge clk);
      timer_irq <= 1'b0;
      uart_irq  <= 1'b0;
      repeat (4) @(posedge clk);  // let the synchronizer settle
      pend_m = pend_m | {1'b0, src};
      check_pending();
      mask = 3'(rand_bits(3));
      pend_m = pend_m & ~mask;  // write one to clear
      bus_write({REG_IRQ, 16'h0000}, {29'(rand_bits(29)), mask}, 4'hf);
      @(negedge clk);
      check("irq_req after clear", 32'(irq_req), 32'(|pend_m));
    end
  endtask

  task automatic hid_words();
    logic [31:0] w, exp;
    for (int r = 0; r < N_HID; r++) begin
      w = rand_bits(32);
      if (r[0]) w[28] = ^w[24:0];  // odd rounds carry good parity
      for (int i = 0; i < 32; i++) begin  // lsb first
        hold_pins(1'b0, 1'b0, w[i]);
        hold_pins(1'b1, 1'b0, w[i]);
      end
      hold_pins(1'b0, 1'b0, 1'b0);
      hold_pins(1'b0, 1'b1, 1'b0);
      hold_pins(1'b0, 1'b0, 1'b0);
      exp = ((^w[24:0]) == w[28]) ? w : 32'd0;
      read_expect("hid word", {REG_HID, 16'(rand_bits(16))}, exp);
      read_expect("hid second read", {REG_HID, 16'h0000}, 32'd0);
      pend_m = pend_m | 3'b100;  // strobe always raises bit 2
      check_pending();
      bus_write({REG_IRQ, 16'h0000}, 32'h7, 4'hf);
      pend_m = '0;
    end
  endtask

  task automatic unmapped_reads();
    logic [15:0] reg_code;
    for (int n = 0; n < 8; n++) begin
      reg_code = 16'(rand_bits(16));
      if (reg_code[15:4] == 12'h020) reg_code = 16'h0300 + {12'h0, reg_code[3:0]};
      read_expect("unmapped readdata", {reg_code, 16'(rand_bits(16))}, 32'd0);
    end
    read_expect("unmapped 0x0203", {16'h0203, 16'h0000}, 32'd0);
  endtask

  // watchdog
  initial begin
    repeat (OPS * 40) @(posedge clk);
    $display("Timeout: the tests did not finish in the allowed number of cycles");
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    clk     = 1'b0;
    reset_n <= 1'b0;
    bus_req <= '0;
    timer_irq <= 1'b0;
    uart_irq  <= 1'b0;
    hid_dat   <= 1'b0;
    hid_clk   <= 1'b0;
    hid_str   <= 1'b0;
    cursor_rd_addr <= '0;
    vga_m  = '0;
    vga_m.mode = 1'b1;  // mode comes out of reset at 1
    fc_m   = 1'b0;
    fp_m   = '0;
    pend_m = '0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
    sram_traffic();
    control_writes();
    cursor_image();
    irq_edges();
    hid_words();
    unmapped_reads();
    repeat (2) @(posedge clk);
    $display("Test passed");
    $finish;
  end

endmodule

//--- compile.f
verilog/fabric_pkg.sv
verilog/bus_fabric.sv
verilog/sram_port.sv
verilog/sys_ctrl.sv
verilog/vga_regs.sv
verilog/hid_rx.sv
verilog/cpu_bus_system.sv
tb/tb_cpu_bus_system.sv

//--- Makefile
SIM  := obj_dir/Vtb_cpu_bus_system
SRCS := $(wildcard verilog/*.sv tb/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_cpu_bus_system -f compile.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
